/* rhythm_game_top.f */
source/game_pkg.sv
source/screen_pkg.sv
source/beat_timebase.sv
source/box_dropper.sv
source/hit_judge.sv
source/frame_renderer.sv
source/rhythm_game_top.sv
tests/rhythm_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and fail if the log reports errors
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rhythm_game_tb \
    -f rhythm_game_top.f \
    -o rhythm_game_sim

./obj_dir/rhythm_game_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

/* tests/rhythm_game_tb.sv */
//==================================================
// scan is driven directly, one frame tick per 4 cycles
// expected values come from a model of ticks and lanes
//==================================================
`timescale 1ns/1ps
`default_nettype none

module rhythm_game_tb;

    logic                 sys_clk = 1'b0;
    logic                 reset;
    logic                 video_on;
    screen_pkg::pos_t     x;
    screen_pkg::pos_t     y;
    game_pkg::key_event_t key_in;
    screen_pkg::rgb_t     rgb;
    logic [7:0]           score;
    logic [3:0]           column_leds;

    // reference model
    int               tick_n;
    logic [4:0]       model_lfsr;
    logic [6:0]       model_count [2];
    logic [1:0]       model_col [2];
    screen_pkg::pos_t model_y [2];
    logic [7:0]       exp_score;
    screen_pkg::rgb_t exp_rgb;
    logic             check_rgb;
    logic [3:0]       match_prev;
    logic             last_tick;
    int               pad_col;      // column of the held key, -1 if none
    int               errors;
    int               err_start;
    int               tests;
    int               failed_tests;
    string            test_name;

    rhythm_game_top i_dut (.*);

    always #5 sys_clk = ~sys_clk;

    function automatic void report_value(string what, int exp, int act);
        errors++;
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endfunction

    function automatic void report_text(string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endfunction

    a_score: assert property (@(posedge sys_clk) disable iff (reset) score == exp_score)
        else report_value("score", exp_score, $sampled(score));
    a_leds_onehot: assert property (@(posedge sys_clk) disable iff (reset) $onehot(column_leds))
        else report_text("column_leds is not one-hot");
    a_leds_model: assert property (@(posedge sys_clk) disable iff (reset)
        column_leds == 4'b0001 << {model_lfsr[4], model_lfsr[2]})
        else report_value("column_leds", 4'b0001 << {model_lfsr[4], model_lfsr[2]},
                          $sampled(column_leds));
    a_pixel: assert property (@(posedge sys_clk) disable iff (reset) check_rgb |-> rgb == exp_rgb)
        else report_value("rgb", exp_rgb, $sampled(rgb));

    // columns whose held key meets a box in its last two steps
    function automatic logic [3:0] model_match();
        logic [3:0] m;
        m = '0;
        for (int c = 0; c < game_pkg::num_cols; c++) begin
            for (int l = 0; l < 2; l++) begin
                if (key_in.valid && key_in.pressed && key_in.code == game_pkg::key_code_col[c]
                    && model_count[l] >= 30 && model_col[l] == 2'(c))
                    m[c] = 1'b1;
            end
        end
        return m;
    endfunction

    task automatic advance_model();
        logic       launch;
        logic [6:0] old;
        tick_n++;
        if (tick_n % game_pkg::step_ticks == 0) begin
            for (int l = 0; l < 2; l++) begin
                old = model_count[l];
                launch = (tick_n % (2 * game_pkg::launch_ticks)) == (l == 0 ? 0 : 240);
                if (old == 0 && launch) begin
                    model_count[l] = 7'd1;
                    model_col[l] = {model_lfsr[4], model_lfsr[2]};
                end else if (old != 0) begin
                    model_count[l] = (old == 31) ? 7'd0 : old + 7'd1;
                end
                if (old == 0 || old == 31)
                    model_y[l] = screen_pkg::box_hidden_y;
                else if (old == 1)
                    model_y[l] = screen_pkg::box_start_y;
                else
                    model_y[l] = model_y[l] + screen_pkg::box_velocity;
            end
        end
        if (tick_n % (2 * game_pkg::second_ticks) == game_pkg::second_ticks)
            model_lfsr = {model_lfsr[3:0], model_lfsr[4] ^ model_lfsr[1]};
    endtask

    task automatic pick_probe();
        int         kind;
        int         l;
        logic [3:0] m;
        kind = $urandom % 5;
        l = $urandom % 2;
        m = model_match();
        video_on = 1'b1;
        check_rgb = 1'b1;
        if (kind == 0 && pad_col >= 0 && m[pad_col]) begin
            x = screen_pkg::col_left[pad_col] - 10'd5;   // widened part of the pad
            y = 10'd432;
            exp_rgb = screen_pkg::match_rgb;
        end else if (kind == 0 && pad_col >= 0) begin
            x = screen_pkg::col_left[pad_col] + 10'd20;
            y = 10'd420;
            exp_rgb = screen_pkg::not_match_rgb;
        end else if (kind == 1 && model_count[l] >= 2 && model_y[l] <= 395) begin
            x = screen_pkg::col_left[model_col[l]] + 10'($urandom % 66);
            y = model_y[l] + 10'd1 + 10'($urandom % 9);
            exp_rgb = screen_pkg::box_rgb;
        end else if (kind == 2) begin
            video_on = 1'b0;
            x = 10'($urandom % 640);
            y = 10'($urandom % 480);
            exp_rgb = '0;
        end else if (kind == 3) begin
            x = 10'($urandom % 240);  // left of the playfield
            y = 10'($urandom % 400);
            exp_rgb = screen_pkg::bg_rgb;
        end else begin
            x = screen_pkg::line_x[$urandom % 5] + 10'($urandom % 2);
            y = 10'($urandom % 480);
            exp_rgb = screen_pkg::line_rgb;
        end
    endtask

    task automatic run_cycle(input logic tick);
        logic [3:0] m;
        logic       score_due;
        if (tick) begin
            x = game_pkg::refresh_tick_x;
            y = game_pkg::refresh_tick_y;
            video_on = 1'b1;
            check_rgb = 1'b0;
        end else begin
            pick_probe();
        end
        m = model_match();
        score_due = |(m & ~match_prev);
        match_prev = m;
        @(posedge sys_clk);
        #1;
        if (score_due)
            exp_score = exp_score + 8'd1;
        if (last_tick)
            advance_model();  // dut state moved on the pulse edge just passed
        last_tick = tick;
    endtask

    task automatic run_frame();
        run_cycle(1'b1);
        repeat (3) run_cycle(1'b0);
    endtask

    task automatic run_to_tick(input int target);
        int guard;
        guard = 0;
        while (tick_n < target && guard < 2000) begin
            run_frame();
            guard++;
        end
        if (tick_n < target)
            report_text($sformatf("timeout waiting for frame tick %0d", target));
    endtask

    // lane < 0 means any lane; returns -1 on timeout
    task automatic wait_count(input logic [6:0] target, inout int lane);
        int guard;
        int found;
        guard = 0;
        found = -1;
        while (found < 0 && guard < 1000) begin
            run_frame();
            guard++;
            for (int l = 0; l < 2; l++) begin
                if (model_count[l] == target && (lane < 0 || lane == l))
                    found = l;
            end
        end
        if (found < 0)
            report_text($sformatf("timeout waiting for a lane count of %0d", target));
        lane = found;
    endtask

    task automatic set_key(input logic valid, input int col);
        key_in.valid = valid;
        key_in.pressed = 1'b1;
        key_in.code = game_pkg::key_code_col[col];
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors > err_start) begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, errors - err_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        int         lane;
        logic [7:0] score_start;
        void'($urandom(44));
        reset = 1'b1;
        video_on = 1'b0;
        x = '0;
        y = '0;
        key_in = '0;
        tick_n = 0;
        model_lfsr = game_pkg::lfsr_init;
        model_count = '{7'd0, 7'd0};
        model_col = '{2'd0, 2'd0};
        model_y = '{screen_pkg::box_hidden_y, screen_pkg::box_hidden_y};
        exp_score = '0;
        exp_rgb = '0;
        check_rgb = 1'b0;
        match_prev = '0;
        last_tick = 1'b0;
        pad_col = -1;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        repeat (3) @(posedge sys_clk);
        #1;
        reset = 1'b0;

        start_test("reset");
        a_reset_state: assert (score == 8'd0 && column_leds == 4'b1000)
            else report_text("score or column_leds wrong after reset");
        run_to_tick(20);
        end_test();
        start_test("leds");
        run_to_tick(400);
        end_test();
        start_test("boxes");
        run_to_tick(640);
        end_test();

        start_test("hit");
        lane = -1;
        wait_count(7'd29, lane);
        if (lane >= 0) begin
            score_start = score;
            pad_col = model_col[lane];
            set_key(1'b1, pad_col);
            wait_count(7'd0, lane);
            key_in = '0;
            pad_col = -1;
            a_hit_once: assert (score == score_start + 8'd1)
                else report_value("score after hit", score_start + 8'd1, score);
        end
        end_test();

        start_test("miss");
        lane = -1;
        wait_count(7'd29, lane);
        if (lane >= 0) begin
            score_start = score;
            pad_col = (model_col[lane] + 1 + $urandom % 3) % 4;  // some other column
            set_key(1'b1, pad_col);
            wait_count(7'd31, lane);
            pad_col = -1;
            set_key(1'b0, model_col[lane]);  // right code but not valid
            wait_count(7'd0, lane);
            key_in = '0;
            a_no_hit: assert (score == score_start)
                else report_value("score after miss", score_start, score);
        end
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* source/rhythm_game_top.sv */
//==================================================
// x/y come from an external scan controller
// key_in must already be a decoded ps/2 event
//==================================================
`timescale 1ns/1ps
`default_nettype none

module rhythm_game_top (
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic                 video_on,
    input  screen_pkg::pos_t     x,
    input  screen_pkg::pos_t     y,
    input  game_pkg::key_event_t key_in,
    output screen_pkg::rgb_t     rgb,
    output logic [7:0]           score,
    output logic [3:0]           column_leds
);

    logic                         step_pulse;
    logic                         second_pulse;
    logic                         launch_odd;
    logic                         launch_even;
    game_pkg::lane_status_t [1:0] lanes;
    logic [3:0]                   col_match;
    logic [3:0]                   key_cols;

    beat_timebase i_timebase (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .x            (x),
        .y            (y),
        .step_pulse   (step_pulse),
        .second_pulse (second_pulse),
        .launch_odd   (launch_odd),
        .launch_even  (launch_even)
    );

    box_dropper i_dropper (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .step_pulse   (step_pulse),
        .second_pulse (second_pulse),
        .launch_odd   (launch_odd),
        .launch_even  (launch_even),
        .lanes        (lanes),
        .column_leds  (column_leds)
    );

    hit_judge i_judge (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .key_in    (key_in),
        .lanes     (lanes),
        .col_match (col_match),
        .key_cols  (key_cols),
        .score     (score)
    );

    frame_renderer i_renderer (
        .x         (x),
        .y         (y),
        .video_on  (video_on),
        .lanes     (lanes),
        .col_match (col_match),
        .key_cols  (key_cols),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

/* source/frame_renderer.sv */
//==================================================
// purely combinational, colour follows x/y at once
// priority: pads, boxes, lines, background
//==================================================
`timescale 1ns/1ps
`default_nettype none

module frame_renderer (
    input  screen_pkg::pos_t             x,
    input  screen_pkg::pos_t             y,
    input  logic                         video_on,
    input  game_pkg::lane_status_t [1:0] lanes,
    input  logic [3:0]                   col_match,
    input  logic [3:0]                   key_cols,
    output screen_pkg::rgb_t             rgb
);

    logic                        hit_any;
    screen_pkg::pos_t            pad_y0;
    screen_pkg::pos_t            pad_y1;
    logic [3:0]                  pad_on;
    logic [1:0]                  box_on;
    logic [screen_pkg::num_lines-1:0] vline_on;
    logic                        line_on;
    screen_pkg::rgb_t            pad_rgb;

    // pads grow vertically while any column hits
    assign hit_any = |col_match;
    assign pad_y0  = screen_pkg::pad_top[hit_any];
    assign pad_y1  = screen_pkg::pad_bottom[hit_any];

    for (genvar c = 0; c < game_pkg::num_cols; c++) begin : g_pad
        screen_pkg::pos_t pad_l;
        screen_pkg::pos_t pad_r;
        screen_pkg::pos_t pad_top_c;

        assign pad_l = col_match[c] ? screen_pkg::col_left[c] - screen_pkg::pad_enlarge
                                    : screen_pkg::col_left[c];
        assign pad_r = col_match[c] ? screen_pkg::col_right[c] + screen_pkg::pad_enlarge
                                    : screen_pkg::col_right[c];
        assign pad_top_c = key_cols[c] ? pad_y0 : pad_y1; // empty when key is up

        assign pad_on[c] = (x >= pad_l) && (x <= pad_r) && (y > pad_top_c) && (y < pad_y1);
    end

    // pads never overlap, even when widened
    assign pad_rgb = |(pad_on & col_match) ? screen_pkg::match_rgb : screen_pkg::not_match_rgb;

    for (genvar l = 0; l < 2; l++) begin : g_box
        screen_pkg::pos_t box_l;
        screen_pkg::pos_t box_r;

        assign box_l = screen_pkg::col_left[lanes[l].col];
        assign box_r = screen_pkg::col_right[lanes[l].col];
        assign box_on[l] = (x >= box_l) && (x <= box_r) && (y > lanes[l].y_top) &&
                           (y < lanes[l].y_top + screen_pkg::box_height);
    end

    for (genvar i = 0; i < screen_pkg::num_lines; i++) begin : g_line
        assign vline_on[i] = (x >= screen_pkg::line_x[i]) &&
                             (x < screen_pkg::line_x[i] + screen_pkg::line_w);
    end

    assign line_on = (|vline_on) || ((y >= screen_pkg::hz_line_top) &&
                     (y < screen_pkg::hz_line_top + screen_pkg::line_w));

    always_comb begin
        if (!video_on)
            rgb = '0;                   // blanking
        else if (|pad_on)
            rgb = pad_rgb;
        else if (|box_on)
            rgb = screen_pkg::box_rgb;  // both lanes share a colour
        else if (line_on)
            rgb = screen_pkg::line_rgb;
        else
            rgb = screen_pkg::bg_rgb;
    end

endmodule

`default_nettype wire

/* source/hit_judge.sv */
//==================================================
// hit window is the last two steps of a flight
// score is 8 bits and wraps, one point per rise
//==================================================
`timescale 1ns/1ps
`default_nettype none

module hit_judge (
    input  logic                         sys_clk,
    input  logic                         reset,
    input  game_pkg::key_event_t         key_in,
    input  game_pkg::lane_status_t [1:0] lanes,
    output logic [3:0]                   col_match,
    output logic [3:0]                   key_cols,
    output logic [7:0]                   score
);

    logic       key_down;
    logic [3:0] col_match_d;
    logic       score_add;

    assign key_down = key_in.valid && key_in.pressed;

    for (genvar c = 0; c < game_pkg::num_cols; c++) begin : g_col
        logic [1:0] lane_near;

        for (genvar l = 0; l < 2; l++) begin : g_lane
            assign lane_near[l] = lanes[l].falling && (lanes[l].col == 2'(c)) &&
                ((lanes[l].count == game_pkg::box_count_max) ||
                 (lanes[l].count == game_pkg::box_count_max - 7'd1));
        end

        assign key_cols[c]  = key_down && (key_in.code == game_pkg::key_code_col[c]);
        assign col_match[c] = key_cols[c] && (|lane_near);
    end

    assign score_add = |(col_match & ~col_match_d); // any column newly matched

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            col_match_d <= '0;
            score       <= '0;
        end else begin
            col_match_d <= col_match;
            if (score_add)
                score <= score + 8'd1;
        end
    end

    // several columns rising together still count once
    a_score_step: assert property (@(posedge sys_clk) disable iff (reset)
        (score == $past(score)) || (score == $past(score) + 8'd1));

endmodule

`default_nettype wire

/* source/box_dropper.sv */
//==================================================
// lanes only move on step_pulse, launches must land
// on a step; y_top lags the count by one step
//==================================================
`timescale 1ns/1ps
`default_nettype none

module box_dropper (
    input  logic                         sys_clk,
    input  logic                         reset,
    input  logic                         step_pulse,
    input  logic                         second_pulse,
    input  logic                         launch_odd,
    input  logic                         launch_even,
    output game_pkg::lane_status_t [1:0] lanes,
    output logic [3:0]                   column_leds
);

    logic [4:0] lfsr;
    logic [1:0] lfsr_col;
    logic [1:0] launch;

    // column picker, one shift per second
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            lfsr <= game_pkg::lfsr_init;
        end else if (second_pulse) begin
            lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[1]};
        end
    end

    assign lfsr_col    = {lfsr[4], lfsr[2]};
    assign column_leds = 4'b0001 << lfsr_col;

    assign launch = {launch_even, launch_odd}; // lane 0 odd, lane 1 even

    for (genvar i = 0; i < 2; i++) begin : g_lane
        game_pkg::lane_state_t state;
        logic [6:0]            count;
        logic [1:0]            col;
        screen_pkg::pos_t      y_top;

        always_ff @(posedge sys_clk or posedge reset) begin
            if (reset) begin
                state <= game_pkg::lane_idle;
                count <= '0;
                col   <= '0;
            end else if (step_pulse) begin
                case (state)
                    game_pkg::lane_idle: begin
                        if (launch[i]) begin
                            state <= game_pkg::lane_falling;
                            count <= 7'd1;
                            col   <= lfsr_col;  // latch the current pick
                        end
                    end
                    game_pkg::lane_falling: begin
                        if (count == game_pkg::box_count_max) begin
                            state <= game_pkg::lane_idle;
                            count <= '0;
                        end else begin
                            count <= count + 7'd1;
                        end
                    end
                endcase
            end
        end

        // position from the old count, box shows one step after launch
        always_ff @(posedge sys_clk or posedge reset) begin
            if (reset) begin
                y_top <= screen_pkg::box_hidden_y;
            end else if (step_pulse) begin
                if (count == '0 || count == game_pkg::box_count_max)
                    y_top <= screen_pkg::box_hidden_y;
                else if (count == 7'd1)
                    y_top <= screen_pkg::box_start_y;
                else
                    y_top <= y_top + screen_pkg::box_velocity;
            end
        end

        assign lanes[i] = '{
            falling: (state == game_pkg::lane_falling),
            col:     col,
            count:   count,
            y_top:   y_top
        };

        a_count_range: assert property (@(posedge sys_clk) disable iff (reset)
            count <= game_pkg::box_count_max);
    end

    a_leds_onehot: assert property (@(posedge sys_clk) disable iff (reset)
        $onehot(column_leds));

endmodule

`default_nettype wire

/* source/beat_timebase.sv */
//==================================================
// any cycle showing the tick position is a tick
// pulses come one cycle after the completing tick
//==================================================
`timescale 1ns/1ps
`default_nettype none

module beat_timebase (
    input  logic             sys_clk,
    input  logic             reset,
    input  screen_pkg::pos_t x,
    input  screen_pkg::pos_t y,
    output logic             step_pulse,
    output logic             second_pulse,
    output logic             launch_odd,
    output logic             launch_even
);

    logic refresh_tick;
    logic [$clog2(game_pkg::step_ticks)-1:0]   step_cnt;
    logic [$clog2(game_pkg::second_ticks)-1:0] second_cnt;
    logic [$clog2(game_pkg::launch_ticks)-1:0] launch_cnt;
    logic step_flag, step_flag_d;
    logic second_flag, second_flag_d;
    logic launch_flag, launch_flag_d;

    // start of vertical retrace
    assign refresh_tick = (y == game_pkg::refresh_tick_y) && (x == game_pkg::refresh_tick_x);

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            step_cnt    <= '0;
            second_cnt  <= '0;
            launch_cnt  <= '0;
            step_flag   <= 1'b0;
            second_flag <= 1'b0;
            launch_flag <= 1'b0;
        end else if (refresh_tick) begin
            step_cnt   <= (step_cnt == game_pkg::step_ticks - 1) ? '0 : step_cnt + 1'b1;
            second_cnt <= (second_cnt == game_pkg::second_ticks - 1) ? '0 : second_cnt + 1'b1;
            launch_cnt <= (launch_cnt == game_pkg::launch_ticks - 1) ? '0 : launch_cnt + 1'b1;
            if (step_cnt == game_pkg::step_ticks - 1)
                step_flag <= ~step_flag;
            if (second_cnt == game_pkg::second_ticks - 1)
                second_flag <= ~second_flag;
            if (launch_cnt == game_pkg::launch_ticks - 1)
                launch_flag <= ~launch_flag;
        end
    end

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            step_flag_d   <= 1'b0;
            second_flag_d <= 1'b0;
            launch_flag_d <= 1'b0;
        end else begin
            step_flag_d   <= step_flag;
            second_flag_d <= second_flag;
            launch_flag_d <= launch_flag;
        end
    end

    assign step_pulse   = step_flag ^ step_flag_d;       // every toggle
    assign second_pulse = second_flag & ~second_flag_d;  // rising only
    assign launch_even  = launch_flag & ~launch_flag_d;  // 0 -> 1, comes first
    assign launch_odd   = ~launch_flag & launch_flag_d;

endmodule

`default_nettype wire

/* source/screen_pkg.sv */
//==================================================
// x ranges are inclusive, box and pad rows are open
// lines are two pixels wide from their left/top edge
//==================================================
`default_nettype none

package screen_pkg;

    typedef logic [11:0] rgb_t;
    typedef logic [9:0]  pos_t;

    // playfield columns
    localparam pos_t col_left  [4] = '{10'd252, 10'd342, 10'd432, 10'd522};
    localparam pos_t col_right [4] = '{10'd317, 10'd407, 10'd497, 10'd587};

    // vertical separators and the hit line
    localparam int   num_lines   = 5;
    localparam pos_t line_x [num_lines] = '{10'd240, 10'd330, 10'd420, 10'd510, 10'd600};
    localparam pos_t line_w      = 10'd2;
    localparam pos_t hz_line_top = 10'd423;

    localparam pos_t box_height   = 10'd10;
    localparam pos_t box_start_y  = 10'd40;
    localparam pos_t box_hidden_y = 10'd480; // below the visible area
    localparam pos_t box_velocity = 10'd13;  // pixels per step

    // pad rows, index 1 while any hit is active
    localparam pos_t pad_top    [2] = '{10'd416, 10'd410};
    localparam pos_t pad_bottom [2] = '{10'd430, 10'd434};
    localparam pos_t pad_enlarge    = 10'd10;

    localparam rgb_t bg_rgb        = 12'h035;
    localparam rgb_t line_rgb      = 12'h9BD;
    localparam rgb_t box_rgb       = 12'hFD7;
    localparam rgb_t match_rgb     = 12'hFAB;
    localparam rgb_t not_match_rgb = 12'hBCC;

endpackage

`default_nettype wire

/* source/game_pkg.sv */
//==================================================
// frame tick assumes a 640x480 scan reaching y 481
// all game timing is counted in frame ticks
//==================================================
`default_nettype none

package game_pkg;

    // scan position at start of vertical retrace
    localparam logic [9:0] refresh_tick_y = 10'd481;
    localparam logic [9:0] refresh_tick_x = 10'd0;

    localparam int step_ticks   = 15;  // ticks per fall step
    localparam int second_ticks = 120; // half period of second flag
    localparam int launch_ticks = 240; // half period of launch flag

    localparam logic [6:0] box_count_max = 7'd31; // last step of a flight
    localparam logic [4:0] lfsr_init     = 5'b10100;

    localparam int num_cols = 4;

    // ps/2 make codes of keys 1 to 4, one per column
    localparam logic [8:0] key_code_col [num_cols] = '{9'h16, 9'h1e, 9'h26, 9'h25};

    typedef enum logic {
        lane_idle,
        lane_falling
    } lane_state_t;

    typedef struct packed {
        logic       valid;   // decoder output meaningful
        logic       pressed; // key held down
        logic [8:0] code;
    } key_event_t;

    typedef struct packed {
        logic       falling;
        logic [1:0] col;
        logic [6:0] count;   // steps since launch
        logic [9:0] y_top;
    } lane_status_t;

endpackage

`default_nettype wire
